// File: project.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/instr_decoder.sv
verilog/branch_target_unit.sv
verilog/register_file.sv
verilog/main_control.sv
verilog/decode_stage.sv
sim/tb_decode_stage.sv

// File: sim/tb_decode_stage.sv
`timescale 1ns/1ps

`include "mips_config.svh"

module tb_decode_stage;

    localparam int TIMEOUT_CYCLES = 2000;

    logic               clock;
    logic               soft_reset;
    isa_pkg::word_t     instruction;
    isa_pkg::pc_addr_t  return_pc;
    logic               enable_pipeline;
    logic               bubble;
    logic               flush;
    logic               wb_write;
    isa_pkg::reg_addr_t wb_addr;
    isa_pkg::word_t     wb_data;
    isa_pkg::reg_addr_t debug_addr;
    pipe_pkg::id_ex_t   id_ex;
    isa_pkg::word_t     data_a;
    isa_pkg::word_t     data_b;
    isa_pkg::word_t     debug_data;
    isa_pkg::pc_addr_t  jump_target;
    logic               jump_taken;
    logic               jump_exception;
    isa_pkg::reg_addr_t hazard_rs;
    isa_pkg::reg_addr_t hazard_rt;

    logic [31:0]        lfsr;
    isa_pkg::word_t     model [`MIPS_NUM_REGS];
    string              test_name;
    int                 errors;
    int                 checks;
    int                 cycles;

    decode_stage UUT (
        .i_clock           (clock),
        .i_soft_reset      (soft_reset),
        .i_instruction     (instruction),
        .i_return_pc       (return_pc),
        .i_enable_pipeline (enable_pipeline),
        .i_bubble          (bubble),
        .i_flush           (flush),
        .i_wb_write        (wb_write),
        .i_wb_addr         (wb_addr),
        .i_wb_data         (wb_data),
        .i_debug_addr      (debug_addr),
        .o_id_ex           (id_ex),
        .o_data_a          (data_a),
        .o_data_b          (data_b),
        .o_debug_data      (debug_data),
        .o_jump_target     (jump_target),
        .o_jump_taken      (jump_taken),
        .o_jump_exception  (jump_exception),
        .o_hazard_rs       (hazard_rs),
        .o_hazard_rt       (hazard_rt)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without reaching the end of the tests", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers.
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        lfsr_next = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic isa_pkg::word_t encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                                input logic [4:0] rd, input logic [4:0] shamt,
                                                input isa_pkg::funct_e funct);
        encode_r = {isa_pkg::OP_SPECIAL, rs, rt, rd, shamt, funct};
    endfunction

    function automatic isa_pkg::word_t encode_i(input isa_pkg::opcode_e op, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
        encode_i = {op, rs, rt, imm};
    endfunction

    function automatic isa_pkg::word_t encode_j(input isa_pkg::opcode_e op,
                                                input logic [25:0] index);
        encode_j = {op, index};
    endfunction

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, field, expected, actual);
        end
    endtask

    // Write lands on the second rising edge.
    task automatic write_reg(input isa_pkg::reg_addr_t addr, input isa_pkg::word_t data);
        @(posedge clock);
        wb_write <= 1'b1;
        wb_addr  <= addr;
        wb_data  <= data;
        @(posedge clock);
        wb_write <= 1'b0;
    endtask

    task automatic apply_instr(input isa_pkg::word_t instr);
        @(posedge clock);
        instruction <= instr;
        @(posedge clock);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests.
    ////////////////////////////////////////////////////////////

    task automatic verify_registers();
        logic [31:0] value;
        test_name = "registers";
        for (int i = 1; i < `MIPS_NUM_REGS; i++) begin
            random_bits(32, value);
            model[i] = value;
            write_reg(i, value);
        end
        for (int i = 1; i < `MIPS_NUM_REGS; i++) begin
            @(posedge clock);
            debug_addr  <= i;
            instruction <= encode_r(i, 32 - i, 0, 0, isa_pkg::FN_ADDU);
            @(posedge clock);
            check_value("debug", model[i], debug_data);
            check_value("data_a", model[i], data_a);
            check_value("data_b", model[32 - i], data_b);
        end
        write_reg(0, 32'hDEAD_BEEF);
        @(posedge clock);
        debug_addr  <= 0;
        instruction <= encode_r(0, 0, 0, 0, isa_pkg::FN_ADDU);
        @(posedge clock);
        check_value("r0 debug", 32'h0, debug_data);
        check_value("r0 data_a", 32'h0, data_a);
    endtask

    task automatic rtype_controls();
        isa_pkg::funct_e     functs [10];
        pipe_pkg::alu_ctrl_e alus [10];
        logic [31:0]         fields;
        test_name = "rtype";
        functs = '{isa_pkg::FN_SLL, isa_pkg::FN_SRL, isa_pkg::FN_SRA, isa_pkg::FN_ADDU,
                   isa_pkg::FN_SUBU, isa_pkg::FN_AND, isa_pkg::FN_OR, isa_pkg::FN_XOR,
                   isa_pkg::FN_NOR, isa_pkg::FN_SLT};
        alus = '{pipe_pkg::ALU_SLL, pipe_pkg::ALU_SRL, pipe_pkg::ALU_SRA, pipe_pkg::ALU_ADD,
                 pipe_pkg::ALU_SUB, pipe_pkg::ALU_AND, pipe_pkg::ALU_OR, pipe_pkg::ALU_XOR,
                 pipe_pkg::ALU_NOR, pipe_pkg::ALU_SLT};
        for (int i = 0; i < 10; i++) begin
            random_bits(15, fields);
            apply_instr(encode_r(fields[14:10], fields[9:5], fields[4:0], 0, functs[i]));
            check_value("reg_dst", 1'b1, id_ex.ctrl.reg_dst);
            check_value("reg_write", 1'b1, id_ex.ctrl.reg_write);
            check_value("alu_op", pipe_pkg::ALU_OP_RTYPE, id_ex.ctrl.alu_op);
            check_value("alu_ctrl", alus[i], id_ex.ctrl.alu_ctrl);
            check_value("rs", fields[14:10], id_ex.rs);
            check_value("rt", fields[9:5], id_ex.rt);
            check_value("rd", fields[4:0], id_ex.rd);
            check_value("hazard_rs", fields[14:10], hazard_rs);
            check_value("hazard_rt", fields[9:5], hazard_rt);
        end
    endtask

    task automatic immediate_forms();
        isa_pkg::opcode_e ops [14];
        logic [31:0]      fields;
        logic [15:0]      imm;
        logic             load;
        logic             store;
        pipe_pkg::mem_size_e size;
        test_name = "immediate";
        ops = '{isa_pkg::OP_ADDI, isa_pkg::OP_SLTI, isa_pkg::OP_ANDI, isa_pkg::OP_ORI,
                isa_pkg::OP_XORI, isa_pkg::OP_LUI, isa_pkg::OP_LB, isa_pkg::OP_LH,
                isa_pkg::OP_LW, isa_pkg::OP_LBU, isa_pkg::OP_LHU, isa_pkg::OP_SB,
                isa_pkg::OP_SH, isa_pkg::OP_SW};
        for (int i = 0; i < 28; i++) begin
            random_bits(25, fields);
            // Even passes positive, odd passes negative.
            imm   = {i[0], fields[14:0]};
            load  = (i / 2 >= 6) && (i / 2 <= 10);
            store = (i / 2 >= 11);
            case (ops[i / 2])
                isa_pkg::OP_LB, isa_pkg::OP_SB: size = pipe_pkg::MEM_BYTE;
                isa_pkg::OP_LH, isa_pkg::OP_SH: size = pipe_pkg::MEM_HALF;
                isa_pkg::OP_LW, isa_pkg::OP_SW: size = pipe_pkg::MEM_WORD;
                isa_pkg::OP_LBU:                size = pipe_pkg::MEM_BYTE_U;
                isa_pkg::OP_LHU:                size = pipe_pkg::MEM_HALF_U;
                default:                        size = pipe_pkg::MEM_NONE;
            endcase
            apply_instr(encode_i(ops[i / 2], fields[24:20], fields[19:15], imm));
            check_value("imm_ext", i[0] ? {16'hFFFF, imm} : {16'h0000, imm}, id_ex.imm_ext);
            check_value("alu_src", 1'b1, id_ex.ctrl.alu_src);
            check_value("reg_write", !store, id_ex.ctrl.reg_write);
            check_value("mem_read", load, id_ex.ctrl.mem_read);
            check_value("mem_to_reg", load, id_ex.ctrl.mem_to_reg);
            check_value("mem_write", store, id_ex.ctrl.mem_write);
            check_value("mem_size", size, id_ex.ctrl.mem_size);
            check_value("rs", fields[24:20], id_ex.rs);
            check_value("rt", fields[19:15], id_ex.rt);
        end
    endtask

    task automatic jump_resolution();
        logic [31:0] value;
        test_name = "jumps";
        random_bits(11, value);
        return_pc <= value[10:0];
        apply_instr(encode_j(isa_pkg::OP_J, 26'h000_02A5));
        check_value("J target", 11'h2A5, jump_target);
        check_value("J taken", 1'b1, jump_taken);
        check_value("J in range exception", 1'b0, jump_exception);
        check_value("J latched taken", 1'b1, id_ex.jump_taken);
        check_value("return_pc", value[10:0], id_ex.return_pc);
        apply_instr(encode_j(isa_pkg::OP_JAL, 26'h000_07FF));
        check_value("JAL target", 11'h7FF, id_ex.jump_target);
        check_value("JAL rd", 5'd31, id_ex.rd);
        check_value("JAL reg_write", 1'b1, id_ex.ctrl.reg_write);
        apply_instr(encode_j(isa_pkg::OP_J, 26'h000_0800));
        check_value("J exception", 1'b1, jump_exception);
        check_value("J out of range taken", 1'b0, jump_taken);
        write_reg(5, {21'b0, value[10:0]});
        apply_instr(encode_r(5, 0, 0, 0, isa_pkg::FN_JR));
        check_value("JR target", value[10:0], jump_target);
        check_value("JR taken", 1'b1, jump_taken);
        apply_instr(encode_r(5, 0, 9, 0, isa_pkg::FN_JALR));
        check_value("JALR taken", 1'b1, id_ex.jump_taken);
        check_value("JALR reg_write", 1'b1, id_ex.ctrl.reg_write);
        random_bits(32, value);
        write_reg(6, value | 32'h8000_0000);
        apply_instr(encode_r(6, 0, 0, 0, isa_pkg::FN_JR));
        check_value("JR exception", 1'b1, jump_exception);
        check_value("JR out of range taken", 1'b0, jump_taken);
    endtask

    task automatic stall_and_bubble();
        pipe_pkg::ctrl_t  bubble_ctrl;
        pipe_pkg::id_ex_t snapshot;
        test_name = "stall";
        bubble_ctrl          = '0;
        bubble_ctrl.alu_ctrl = pipe_pkg::ALU_ADD;
        apply_instr(encode_i(isa_pkg::OP_ADDI, 3, 4, 16'h8001));
        check_value("loaded imm_ext", 32'hFFFF_8001, id_ex.imm_ext);
        instruction <= encode_i(isa_pkg::OP_LW, 7, 8, 16'h0040);
        bubble      <= 1'b1;
        @(posedge clock);
        check_value("bubble ctrl", bubble_ctrl, id_ex.ctrl);
        check_value("bubble rs", 5'd3, id_ex.rs);
        check_value("bubble rt", 5'd4, id_ex.rt);
        // Bits 15..11 of the ADDI immediate.
        check_value("bubble rd", 5'd16, id_ex.rd);
        check_value("bubble imm_ext", 32'hFFFF_8001, id_ex.imm_ext);
        bubble <= 1'b0;
        flush  <= 1'b1;
        @(posedge clock);
        check_value("flush ctrl", bubble_ctrl, id_ex.ctrl);
        check_value("flush rs", 5'd3, id_ex.rs);
        flush <= 1'b0;
        @(posedge clock);
        check_value("reload mem_read", 1'b1, id_ex.ctrl.mem_read);
        snapshot = id_ex;
        enable_pipeline <= 1'b0;
        instruction     <= encode_r(1, 2, 3, 0, isa_pkg::FN_SUBU);
        repeat (2) @(posedge clock);
        checks++;
        if (id_ex !== snapshot) begin
            errors++;
            $display("** Error %s hold: expected %h, actual %h", test_name, snapshot, id_ex);
        end
        enable_pipeline <= 1'b1;
    endtask

    task automatic halt_and_reset();
        test_name = "halt";
        apply_instr(`MIPS_HALT_WORD);
        check_value("halt", 1'b1, id_ex.halt);
        check_value("latched taken", 1'b0, id_ex.jump_taken);
        check_value("jump taken", 1'b0, jump_taken);
        soft_reset <= 1'b0;
        @(posedge clock);
        check_value("halt after reset", 1'b0, id_ex.halt);
        checks++;
        if (id_ex !== '0) begin
            errors++;
            $display("** Error %s reset bundle: expected 0, actual %h", test_name, id_ex);
        end
        soft_reset <= 1'b1;
    endtask

    initial begin
        soft_reset      = 1'b0;
        instruction     = '0;
        return_pc       = '0;
        enable_pipeline = 1'b1;
        bubble          = 1'b0;
        flush           = 1'b0;
        wb_write        = 1'b0;
        wb_addr         = '0;
        wb_data         = '0;
        debug_addr      = '0;
        lfsr            = 32'he1a460b2;
        errors          = 0;
        checks          = 0;
        cycles          = 0;
        test_name       = "reset";
        repeat (10) @(posedge clock);
        checks++;
        if (id_ex !== '0) begin
            errors++;
            $display("** Error %s bundle: expected 0, actual %h", test_name, id_ex);
        end
        soft_reset <= 1'b1;
        verify_registers();
        rtype_controls();
        immediate_forms();
        jump_resolution();
        stall_and_bubble();
        halt_and_reset();
        @(posedge clock);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/branch_target_unit.sv
`timescale 1ns/1ps

module branch_target_unit (
    input  isa_pkg::jump_kind_e  i_jump_kind,
    input  isa_pkg::jump_index_t i_jump_index,
    input  isa_pkg::word_t       i_reg_target,
    output isa_pkg::pc_addr_t    o_target,
    output logic                 o_taken,
    output logic                 o_exception
);

    localparam int ADDR_BITS  = $bits(isa_pkg::pc_addr_t);
    localparam int INDEX_BITS = $bits(isa_pkg::jump_index_t);
    localparam int WORD_BITS  = $bits(isa_pkg::word_t);

    isa_pkg::pc_addr_t raw_target;
    logic              upper_set;
    logic              is_jump;

    always_comb begin
        raw_target = '0;
        upper_set  = 1'b0;
        is_jump    = 1'b0;
        case (i_jump_kind)
            isa_pkg::JUMP_J, isa_pkg::JUMP_JAL: begin
                is_jump    = 1'b1;
                raw_target = i_jump_index[ADDR_BITS-1:0];
                upper_set  = |i_jump_index[INDEX_BITS-1:ADDR_BITS];
            end
            isa_pkg::JUMP_JR, isa_pkg::JUMP_JALR: begin
                is_jump    = 1'b1;
                raw_target = i_reg_target[ADDR_BITS-1:0];
                upper_set  = |i_reg_target[WORD_BITS-1:ADDR_BITS];
            end
            default: begin
                is_jump = 1'b0;
            end
        endcase
    end

    // Target outside instruction memory, jump is cancelled.
    assign o_exception = is_jump & upper_set;
    assign o_taken     = is_jump & ~upper_set;
    assign o_target    = o_taken ? raw_target : '0;

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

`include "mips_config.svh"

module decode_stage (
    input  logic                i_clock,
    input  logic                i_soft_reset,
    input  isa_pkg::word_t      i_instruction,
    input  isa_pkg::pc_addr_t   i_return_pc,
    input  logic                i_enable_pipeline,
    input  logic                i_bubble,
    input  logic                i_flush,
    input  logic                i_wb_write,
    input  isa_pkg::reg_addr_t  i_wb_addr,
    input  isa_pkg::word_t      i_wb_data,
    input  isa_pkg::reg_addr_t  i_debug_addr,
    output pipe_pkg::id_ex_t    o_id_ex,
    output isa_pkg::word_t      o_data_a,
    output isa_pkg::word_t      o_data_b,
    output isa_pkg::word_t      o_debug_data,
    output isa_pkg::pc_addr_t   o_jump_target,
    output logic                o_jump_taken,
    output logic                o_jump_exception,
    output isa_pkg::reg_addr_t  o_hazard_rs,
    output isa_pkg::reg_addr_t  o_hazard_rt
);

    localparam int WORD_BITS = $bits(isa_pkg::word_t);
    localparam int IMM_BITS  = $bits(isa_pkg::imm_t);

    // Control fields of a nop inserted by a stall or a flush.
    localparam pipe_pkg::ctrl_t BUBBLE_CTRL = '{
        alu_ctrl: pipe_pkg::alu_ctrl_e'(`MIPS_ALU_BUBBLE),
        mem_size: pipe_pkg::MEM_NONE,
        default:  '0
    };

    isa_pkg::reg_addr_t   rs;
    isa_pkg::reg_addr_t   rt;
    isa_pkg::reg_addr_t   rd;
    isa_pkg::imm_t        imm;
    isa_pkg::jump_index_t jump_index;
    isa_pkg::jump_kind_e  jump_kind;
    logic                 halt;
    pipe_pkg::ctrl_t      ctrl;
    isa_pkg::word_t       imm_ext;
    pipe_pkg::id_ex_t     id_ex_next;

    instr_decoder u_instr_decoder (
        .i_instruction (i_instruction),
        .o_rs          (rs),
        .o_rt          (rt),
        .o_rd          (rd),
        .o_imm         (imm),
        .o_jump_index  (jump_index),
        .o_jump_kind   (jump_kind),
        .o_halt        (halt)
    );

    register_file u_register_file (
        .i_clock      (i_clock),
        .i_soft_reset (i_soft_reset),
        .i_rs         (rs),
        .i_rt         (rt),
        .i_debug_addr (i_debug_addr),
        .i_wb_write   (i_wb_write),
        .i_wb_addr    (i_wb_addr),
        .i_wb_data    (i_wb_data),
        .o_data_a     (o_data_a),
        .o_data_b     (o_data_b),
        .o_debug_data (o_debug_data)
    );

    // Register jumps take their target from data A.
    branch_target_unit u_branch_target_unit (
        .i_jump_kind  (jump_kind),
        .i_jump_index (jump_index),
        .i_reg_target (o_data_a),
        .o_target     (o_jump_target),
        .o_taken      (o_jump_taken),
        .o_exception  (o_jump_exception)
    );

    main_control u_main_control (
        .i_opcode (isa_pkg::opcode_e'(i_instruction[31:26])),
        .i_funct  (isa_pkg::funct_e'(i_instruction[5:0])),
        .o_ctrl   (ctrl)
    );

    assign o_hazard_rs = rs;
    assign o_hazard_rt = rt;

    assign imm_ext = {{(WORD_BITS - IMM_BITS){imm[IMM_BITS-1]}}, imm};

    always_comb begin
        id_ex_next             = '0;
        id_ex_next.ctrl        = ctrl;
        id_ex_next.imm_ext     = imm_ext;
        id_ex_next.rs          = rs;
        id_ex_next.rt          = rt;
        id_ex_next.rd          = rd;
        id_ex_next.return_pc   = i_return_pc;
        id_ex_next.jump_target = o_jump_target;
        id_ex_next.jump_taken  = o_jump_taken;
        id_ex_next.halt        = halt;
    end

    ////////////////////////////////////////////////////////////
    // ID/EX register, clocked on the falling edge.
    ////////////////////////////////////////////////////////////

    always_ff @(negedge i_clock) begin
        if (!i_soft_reset) begin
            o_id_ex <= '0;
        end else if (i_enable_pipeline) begin
            if (i_bubble || i_flush) begin
                // Operand fields hold, only control is squashed.
                o_id_ex.ctrl <= BUBBLE_CTRL;
            end else begin
                o_id_ex <= id_ex_next;
            end
        end
    end

endmodule

// File: verilog/instr_decoder.sv
`timescale 1ns/1ps

`include "mips_config.svh"

module instr_decoder (
    input  isa_pkg::word_t      i_instruction,
    output isa_pkg::reg_addr_t  o_rs,
    output isa_pkg::reg_addr_t  o_rt,
    output isa_pkg::reg_addr_t  o_rd,
    output isa_pkg::imm_t       o_imm,
    output isa_pkg::jump_index_t o_jump_index,
    output isa_pkg::jump_kind_e o_jump_kind,
    output logic                o_halt
);

    // Link register written by JAL.
    localparam isa_pkg::reg_addr_t LINK_REG = '1;

    isa_pkg::opcode_e opcode;
    isa_pkg::funct_e  funct;

    assign opcode = isa_pkg::opcode_e'(i_instruction[31:26]);
    assign funct  = isa_pkg::funct_e'(i_instruction[5:0]);

    assign o_rs         = i_instruction[25:21];
    assign o_rt         = i_instruction[20:16];
    assign o_imm        = i_instruction[15:0];
    assign o_jump_index = i_instruction[25:0];

    assign o_halt = (i_instruction == `MIPS_HALT_WORD);

    assign o_rd = (opcode == isa_pkg::OP_JAL) ? LINK_REG : i_instruction[15:11];

    ////////////////////////////////////////////////////////////
    // Jump classification.
    ////////////////////////////////////////////////////////////

    always_comb begin
        o_jump_kind = isa_pkg::JUMP_NONE;
        if (!o_halt) begin
            case (opcode)
                isa_pkg::OP_J: begin
                    o_jump_kind = isa_pkg::JUMP_J;
                end
                isa_pkg::OP_JAL: begin
                    o_jump_kind = isa_pkg::JUMP_JAL;
                end
                isa_pkg::OP_SPECIAL: begin
                    if (funct == isa_pkg::FN_JR) begin
                        o_jump_kind = isa_pkg::JUMP_JR;
                    end else if (funct == isa_pkg::FN_JALR) begin
                        o_jump_kind = isa_pkg::JUMP_JALR;
                    end
                end
                default: begin
                    o_jump_kind = isa_pkg::JUMP_NONE;
                end
            endcase
        end
    end

endmodule

// File: verilog/isa_pkg.sv
`include "mips_config.svh"

package isa_pkg;

    localparam int OPCODE_BITS = 6;
    localparam int FUNCT_BITS  = 6;

    typedef logic [31:0]                          word_t;
    typedef logic [$clog2(`MIPS_NUM_REGS)-1:0]    reg_addr_t;
    typedef logic [15:0]                          imm_t;
    typedef logic [25:0]                          jump_index_t;
    typedef logic [`MIPS_ADDR_BITS-1:0]           pc_addr_t;

    // Primary opcode, bits 31..26.
    typedef enum logic [OPCODE_BITS-1:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_ADDI    = 6'h08,
        OP_SLTI    = 6'h0A,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F,
        OP_LB      = 6'h20,
        OP_LH      = 6'h21,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_LHU     = 6'h25,
        OP_SB      = 6'h28,
        OP_SH      = 6'h29,
        OP_SW      = 6'h2B
    } opcode_e;

    // Function code under SPECIAL, bits 5..0.
    typedef enum logic [FUNCT_BITS-1:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        JUMP_NONE = 3'd0,
        JUMP_J    = 3'd1,
        JUMP_JAL  = 3'd2,
        JUMP_JR   = 3'd3,
        JUMP_JALR = 3'd4
    } jump_kind_e;

endpackage

// File: verilog/main_control.sv
`timescale 1ns/1ps

module main_control (
    input  isa_pkg::opcode_e i_opcode,
    input  isa_pkg::funct_e  i_funct,
    output pipe_pkg::ctrl_t  o_ctrl
);

    always_comb begin
        o_ctrl = '0;
        case (i_opcode)
            isa_pkg::OP_SPECIAL: begin
                o_ctrl.reg_dst   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_op    = pipe_pkg::ALU_OP_RTYPE;
                case (i_funct)
                    isa_pkg::FN_SLL:  o_ctrl.alu_ctrl = pipe_pkg::ALU_SLL;
                    isa_pkg::FN_SRL:  o_ctrl.alu_ctrl = pipe_pkg::ALU_SRL;
                    isa_pkg::FN_SRA:  o_ctrl.alu_ctrl = pipe_pkg::ALU_SRA;
                    isa_pkg::FN_ADDU: o_ctrl.alu_ctrl = pipe_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: o_ctrl.alu_ctrl = pipe_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  o_ctrl.alu_ctrl = pipe_pkg::ALU_AND;
                    isa_pkg::FN_OR:   o_ctrl.alu_ctrl = pipe_pkg::ALU_OR;
                    isa_pkg::FN_XOR:  o_ctrl.alu_ctrl = pipe_pkg::ALU_XOR;
                    isa_pkg::FN_NOR:  o_ctrl.alu_ctrl = pipe_pkg::ALU_NOR;
                    isa_pkg::FN_SLT:  o_ctrl.alu_ctrl = pipe_pkg::ALU_SLT;
                    isa_pkg::FN_JR: begin
                        // No write back, target already resolved here.
                        o_ctrl.reg_dst   = 1'b0;
                        o_ctrl.reg_write = 1'b0;
                        o_ctrl.alu_op    = pipe_pkg::ALU_OP_BRANCH;
                    end
                    isa_pkg::FN_JALR: begin
                        o_ctrl.alu_op   = pipe_pkg::ALU_OP_BRANCH;
                        o_ctrl.alu_ctrl = pipe_pkg::ALU_ADD;
                    end
                    default: o_ctrl = '0;
                endcase
            end
            isa_pkg::OP_J: begin
                o_ctrl.alu_op = pipe_pkg::ALU_OP_BRANCH;
            end
            isa_pkg::OP_JAL: begin
                // Link goes to rd, which the decoder sets to 31.
                o_ctrl.reg_dst   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_op    = pipe_pkg::ALU_OP_BRANCH;
                o_ctrl.alu_ctrl  = pipe_pkg::ALU_ADD;
            end
            isa_pkg::OP_ADDI, isa_pkg::OP_SLTI, isa_pkg::OP_ANDI,
            isa_pkg::OP_ORI, isa_pkg::OP_XORI, isa_pkg::OP_LUI: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_op    = pipe_pkg::ALU_OP_IMM;
                case (i_opcode)
                    isa_pkg::OP_SLTI: o_ctrl.alu_ctrl = pipe_pkg::ALU_SLT;
                    isa_pkg::OP_ANDI: o_ctrl.alu_ctrl = pipe_pkg::ALU_AND;
                    isa_pkg::OP_ORI:  o_ctrl.alu_ctrl = pipe_pkg::ALU_OR;
                    isa_pkg::OP_XORI: o_ctrl.alu_ctrl = pipe_pkg::ALU_XOR;
                    isa_pkg::OP_LUI:  o_ctrl.alu_ctrl = pipe_pkg::ALU_LUI;
                    default:          o_ctrl.alu_ctrl = pipe_pkg::ALU_ADD;
                endcase
            end
            isa_pkg::OP_LB, isa_pkg::OP_LH, isa_pkg::OP_LW,
            isa_pkg::OP_LBU, isa_pkg::OP_LHU: begin
                o_ctrl.alu_src    = 1'b1;
                o_ctrl.reg_write  = 1'b1;
                o_ctrl.mem_read   = 1'b1;
                o_ctrl.mem_to_reg = 1'b1;
                o_ctrl.alu_op     = pipe_pkg::ALU_OP_MEM;
                o_ctrl.alu_ctrl   = pipe_pkg::ALU_ADD;
                case (i_opcode)
                    isa_pkg::OP_LB:  o_ctrl.mem_size = pipe_pkg::MEM_BYTE;
                    isa_pkg::OP_LH:  o_ctrl.mem_size = pipe_pkg::MEM_HALF;
                    isa_pkg::OP_LBU: o_ctrl.mem_size = pipe_pkg::MEM_BYTE_U;
                    isa_pkg::OP_LHU: o_ctrl.mem_size = pipe_pkg::MEM_HALF_U;
                    default:         o_ctrl.mem_size = pipe_pkg::MEM_WORD;
                endcase
            end
            isa_pkg::OP_SB, isa_pkg::OP_SH, isa_pkg::OP_SW: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.mem_write = 1'b1;
                o_ctrl.alu_op    = pipe_pkg::ALU_OP_MEM;
                o_ctrl.alu_ctrl  = pipe_pkg::ALU_ADD;
                case (i_opcode)
                    isa_pkg::OP_SB: o_ctrl.mem_size = pipe_pkg::MEM_BYTE;
                    isa_pkg::OP_SH: o_ctrl.mem_size = pipe_pkg::MEM_HALF;
                    default:        o_ctrl.mem_size = pipe_pkg::MEM_WORD;
                endcase
            end
            default: begin
                o_ctrl = '0;
            end
        endcase
    end

endmodule

// File: verilog/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

////////////////////////////////////////////////////////////
// Core sizing.
////////////////////////////////////////////////////////////

// Register file depth.
`define MIPS_NUM_REGS 32

// Instruction memory address width.
`define MIPS_ADDR_BITS 11

////////////////////////////////////////////////////////////
// Special encodings.
////////////////////////////////////////////////////////////

`define MIPS_HALT_WORD 32'hFFFF_FFFF

// ALU code of an inserted bubble, same as add.
`define MIPS_ALU_BUBBLE 4'b0010

`endif

// File: verilog/pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_XOR = 4'b0011,
        ALU_SLL = 4'b0100,
        ALU_SRL = 4'b0101,
        ALU_SUB = 4'b0110,
        ALU_SLT = 4'b0111,
        ALU_SRA = 4'b1000,
        ALU_LUI = 4'b1001,
        ALU_NOR = 4'b1100
    } alu_ctrl_e;

    // ALU class seen by the execute stage.
    typedef logic [1:0] alu_op_t;

    localparam alu_op_t ALU_OP_MEM    = 2'b00;
    localparam alu_op_t ALU_OP_BRANCH = 2'b01;
    localparam alu_op_t ALU_OP_RTYPE  = 2'b10;
    localparam alu_op_t ALU_OP_IMM    = 2'b11;

    typedef enum logic [2:0] {
        MEM_NONE   = 3'd0,
        MEM_BYTE   = 3'd1,
        MEM_HALF   = 3'd2,
        MEM_WORD   = 3'd3,
        MEM_BYTE_U = 3'd4,
        MEM_HALF_U = 3'd5
    } mem_size_e;

    typedef struct packed {
        logic      reg_dst;
        logic      reg_write;
        logic      alu_src;
        alu_op_t   alu_op;
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;
        alu_ctrl_e alu_ctrl;
        mem_size_e mem_size;
    } ctrl_t;

    typedef struct packed {
        ctrl_t              ctrl;
        isa_pkg::word_t     imm_ext;
        isa_pkg::reg_addr_t rs;
        isa_pkg::reg_addr_t rt;
        isa_pkg::reg_addr_t rd;
        isa_pkg::pc_addr_t  return_pc;
        isa_pkg::pc_addr_t  jump_target;
        logic               jump_taken;
        logic               halt;
    } id_ex_t;

endpackage

// File: verilog/register_file.sv
`timescale 1ns/1ps

`include "mips_config.svh"

module register_file (
    input  logic               i_clock,
    input  logic               i_soft_reset,
    input  isa_pkg::reg_addr_t i_rs,
    input  isa_pkg::reg_addr_t i_rt,
    input  isa_pkg::reg_addr_t i_debug_addr,
    input  logic               i_wb_write,
    input  isa_pkg::reg_addr_t i_wb_addr,
    input  isa_pkg::word_t     i_wb_data,
    output isa_pkg::word_t     o_data_a,
    output isa_pkg::word_t     o_data_b,
    output isa_pkg::word_t     o_debug_data
);

    isa_pkg::word_t regs [`MIPS_NUM_REGS];

    logic wb_enable;

    // Register 0 is hardwired to zero.
    assign wb_enable = i_wb_write && (i_wb_addr != '0);

    ////////////////////////////////////////////////////////////
    // Write port.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_enable) begin
            regs[i_wb_addr] <= i_wb_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports.
    ////////////////////////////////////////////////////////////

    // Asynchronous reads, no write bypass.
    assign o_data_a     = regs[i_rs];
    assign o_data_b     = regs[i_rt];
    assign o_debug_data = regs[i_debug_addr];

endmodule
